/* vlog.f */
+incdir+rtl
rtl/align_buffer_pkg.sv
rtl/line_tag_store.sv
rtl/miss_sequencer.sv
rtl/parcel_banks.sv
rtl/inst_assembler.sv
rtl/align_buffer_top.sv
dv/align_buffer_assert.sv
dv/align_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the align buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module align_buffer_tb -o align_buffer_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/align_buffer_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All tests passed" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* dv/align_buffer_tb.sv */
// ======================================================================
// Testbench for the align buffer
// Bound assertions do the checking, this module drives the traffic
// Memory answers a held line request after 1 to 4 cycles
// Requests are held until a valid response and changed on the next edge
// ======================================================================
`timescale 1ns/1ns

module align_buffer_tb;

  logic                         clk;
  logic                         rst_n = 1'b0;
  logic                         flush = 1'b0;
  align_buffer_pkg::fetch_req_t fetch_req = '0;
  align_buffer_pkg::fetch_res_t fetch_res;
  align_buffer_pkg::line_res_t  line_res = '0;
  align_buffer_pkg::line_req_t  line_req;

  integer seed = 32'h1c42;

  // Memory model state
  logic                    mem_busy = 1'b0;
  logic                    mem_fire = 1'b0;
  int                      mem_wait = 0;
  align_buffer_pkg::addr_t mem_addr = '0;

  align_buffer_top align_buffer_top_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .fetch_req_i (fetch_req),
    .fetch_res_o (fetch_res),
    .line_res_i  (line_res),
    .line_req_o  (line_req)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================================================================
  // Lower-level memory
  // ====================================================================
  function automatic align_buffer_pkg::parcel_t mem_parcel(input align_buffer_pkg::addr_t a);
    return a[15:0] ^ 16'hA5C3;
  endfunction

  // Eight parcels, lowest address in the low bits
  function automatic align_buffer_pkg::line_t build_line(input align_buffer_pkg::addr_t base);
    align_buffer_pkg::line_t data;
    for (int i = 0; i < 8; i++) begin
      data[i*16 +: 16] = mem_parcel(base + 32'(2 * i));
    end
    return data;
  endfunction

  // Request picked up at the falling edge, no new pickup in a pulse cycle
  always @(negedge clk) begin
    mem_fire = 1'b0;
    if (!rst_n) begin
      mem_busy = 1'b0;
    end else begin
      if (!mem_busy && !line_res.valid && line_req.valid) begin
        mem_busy = 1'b1;
        mem_addr = line_req.addr;
        mem_wait = 1 + ($random(seed) & 3);
      end
      if (mem_busy) begin
        mem_wait = mem_wait - 1;
        if (mem_wait == 0) begin
          mem_fire = 1'b1;
          mem_busy = 1'b0;
        end
      end
    end
  end

  // One-cycle response pulse
  always @(posedge clk) begin
    line_res.valid <= mem_fire;
    if (mem_fire) begin
      line_res.line <= build_line(mem_addr);
    end
  end

  // ====================================================================
  // Stimulus tasks
  // ====================================================================
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_assertions();
    if (align_buffer_top_inst.align_buffer_assert_inst.fail_count != 0) begin
      stop_with_failure("An assertion failed, see the error line above");
    end
  endtask

  // Hold one request until the buffer answers
  task automatic fetch(input align_buffer_pkg::addr_t addr);
    int cycles;
    @(posedge clk);
    fetch_req.valid <= 1'b1;
    fetch_req.addr  <= addr;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      check_assertions();
      if (cycles > 50) begin
        stop_with_failure($sformatf("No fetch response for address 0x%0h in 50 cycles", addr));
      end
    end while (!fetch_res.valid);
  endtask

  task automatic flush_buffer();
    @(posedge clk);
    fetch_req.valid <= 1'b0;
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    align_buffer_pkg::addr_t addr;
    align_buffer_pkg::addr_t prev;
    int                      r;
    // Live request during reset, it must not reach either side
    @(posedge clk);
    fetch_req.valid <= 1'b1;
    fetch_req.addr  <= 32'h000;
    repeat (9) @(posedge clk);
    fetch_req.valid <= 1'b0;
    rst_n <= 1'b1;
    // Word aligned, halfword offset, then offset 14 with both lines missing
    fetch(32'h000);
    fetch(32'h004);
    fetch(32'h002);
    fetch(32'h01E);
    fetch(32'h01E);
    // Only the next line missing, then only the current line missing
    fetch(32'h040);
    fetch(32'h04E);
    fetch(32'h070);
    fetch(32'h06E);
    // Next line wraps to set 0
    fetch(32'h03E);
    flush_buffer();
    fetch(32'h000);
    // Random halfword addresses, tags alias across the four sets
    prev = 32'h000;
    for (int n = 0; n < 200; n++) begin
      r = $random(seed);
      if (r[3:0] == 4'h0) begin
        flush_buffer();
      end
      if (r[5:4] == 2'b00) begin
        addr = prev;
      end else begin
        addr = $random(seed) & 32'hFE;
      end
      fetch(addr);
      prev = addr;
    end
    @(posedge clk);
    fetch_req.valid <= 1'b0;
    repeat (4) @(negedge clk);
    if (align_buffer_top_inst.align_buffer_assert_inst.fail_count != 0) begin
      stop_with_failure("Assertion failures were counted");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

/* dv/align_buffer_assert.sv */
// ======================================================================
// Concurrent checks for the align buffer, bound to the top level
// Expects memory content parcel(a) = a[15:0] ^ 16'hA5C3
// Fetch requests are assumed held until a valid response
// ======================================================================
`timescale 1ns/1ns
`include "align_buffer_config.svh"

module align_buffer_assert (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         flush_i,
  input align_buffer_pkg::fetch_req_t fetch_req_i,
  input align_buffer_pkg::fetch_res_t fetch_res_i,
  input align_buffer_pkg::line_req_t  line_req_i,
  input align_buffer_pkg::line_res_t  line_res_i,
  input align_buffer_pkg::lookup_t    lookup_i
);

  int                      fail_count = 0;
  logic                    flushed_q;
  logic                    unalign;
  logic                    dbl_resp;
  align_buffer_pkg::addr_t base;

  // Upper parcel at addr+2, lower parcel at addr
  function automatic align_buffer_pkg::inst_t expected_inst(input align_buffer_pkg::addr_t a);
    align_buffer_pkg::parcel_t lo;
    align_buffer_pkg::parcel_t hi;
    lo = a[15:0] ^ 16'hA5C3;
    hi = (a[15:0] + 16'd2) ^ 16'hA5C3;
    return {hi, lo};
  endfunction

  assign base    = fetch_req_i.addr & ~align_buffer_pkg::addr_t'(`AB_LINE_BYTES - 1);
  // Last halfword of a line
  assign unalign = (fetch_req_i.addr - base) == align_buffer_pkg::addr_t'(`AB_LINE_BYTES - 2);
  // First response of a double miss
  assign dbl_resp = fetch_req_i.valid && unalign && lookup_i.odd_miss &&
                    lookup_i.even_miss && line_res_i.valid;

  // Set by a flush, cleared by the next request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      flushed_q <= 1'b0;
    end else if (flush_i) begin
      flushed_q <= 1'b1;
    end else if (fetch_req_i.valid) begin
      flushed_q <= 1'b0;
    end
  end

  // ====================================================================
  // Checks
  // ====================================================================
  inst_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_res_i.valid |-> fetch_res_i.inst == expected_inst(fetch_req_i.addr))
    else begin fail_count++; $error("Fail %0t: wrong instruction data", $time); end

  hit_after_fill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (fetch_req_i.valid && $past(fetch_res_i.valid && !flush_i) &&
     fetch_req_i.addr == $past(fetch_req_i.addr)) |->
    (fetch_res_i.valid && !fetch_res_i.miss && !line_req_i.valid))
    else begin fail_count++; $error("Fail %0t: no hit after fill", $time); end

  req_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    line_req_i.valid |-> (line_req_i.addr == base ||
                          (unalign && line_req_i.addr == base + `AB_LINE_BYTES)))
    else begin fail_count++; $error("Fail %0t: bad line request address", $time); end

  // Double miss order, quiet first response, one idle cycle, then the next line
  dbl_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    dbl_resp |-> !fetch_res_i.valid)
    else begin fail_count++; $error("Fail %0t: valid on first of two fetches", $time); end

  dbl_gap: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    $past(dbl_resp) |-> !line_req_i.valid)
    else begin fail_count++; $error("Fail %0t: line request in skip cycle", $time); end

  dbl_second: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    $past(dbl_resp, 2) |-> (line_req_i.valid && line_req_i.addr == base + `AB_LINE_BYTES))
    else begin fail_count++; $error("Fail %0t: second line request missing", $time); end

  miss_after_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    (flushed_q && fetch_req_i.valid) |-> (fetch_res_i.miss && line_req_i.valid))
    else begin fail_count++; $error("Fail %0t: no miss after flush", $time); end

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> (!line_req_i.valid && !fetch_res_i.valid))
    else begin fail_count++; $error("Fail %0t: activity during reset", $time); end

endmodule

bind align_buffer_top align_buffer_assert align_buffer_assert_inst (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .fetch_req_i (fetch_req_i),
  .fetch_res_i (fetch_res_o),
  .line_req_i  (line_req_o),
  .line_res_i  (line_res_i),
  .lookup_i    (lookup)
);

/* rtl/align_buffer_top.sv */
// ======================================================================
// Align buffer top level
// Returns the 32-bit instruction at any halfword-aligned address
// Hits answer in the request cycle, misses on the response pulse
// No back-pressure on the fetch side or the line side
// ======================================================================
`timescale 1ns/1ns

module align_buffer_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,
  input  align_buffer_pkg::fetch_req_t  fetch_req_i,
  output align_buffer_pkg::fetch_res_t  fetch_res_o,
  input  align_buffer_pkg::line_res_t   line_res_i,
  output align_buffer_pkg::line_req_t   line_req_o
);

  align_buffer_pkg::lookup_t     lookup;
  align_buffer_pkg::fill_t       fill;
  align_buffer_pkg::bank_rows_t  rows;
  align_buffer_pkg::src_sel_t    src_sel;
  logic                          res_valid;
  logic                          res_miss;

  // Tags for current and next line
  line_tag_store line_tag_store_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .fetch_req_i (fetch_req_i),
    .fill_i      (fill),
    .lookup_o    (lookup)
  );

  // Control for single and double misses
  miss_sequencer miss_sequencer_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .fetch_req_i      (fetch_req_i),
    .lookup_i         (lookup),
    .line_res_valid_i (line_res_i.valid),
    .line_req_o       (line_req_o),
    .fill_o           (fill),
    .res_valid_o      (res_valid),
    .res_miss_o       (res_miss),
    .src_sel_o        (src_sel)
  );

  parcel_banks parcel_banks_inst (
    .clk_i    (clk_i),
    .lookup_i (lookup),
    .fill_i   (fill),
    .line_i   (line_res_i.line),
    .rows_o   (rows)
  );

  inst_assembler inst_assembler_inst (
    .lookup_i    (lookup),
    .rows_i      (rows),
    .line_i      (line_res_i.line),
    .src_sel_i   (src_sel),
    .res_valid_i (res_valid),
    .res_miss_i  (res_miss),
    .fetch_res_o (fetch_res_o)
  );

endmodule

/* rtl/inst_assembler.sv */
// ======================================================================
// Instruction assembly from two parcels
// Missing parcels are taken from the line response in its own cycle
// The output is only meaningful while the valid bit is high
// ======================================================================
`timescale 1ns/1ns
`include "align_buffer_config.svh"

module inst_assembler (
  input  align_buffer_pkg::lookup_t     lookup_i,
  input  align_buffer_pkg::bank_rows_t  rows_i,
  input  align_buffer_pkg::line_t       line_i,
  input  align_buffer_pkg::src_sel_t    src_sel_i,
  input  logic                          res_valid_i,
  input  logic                          res_miss_i,
  output align_buffer_pkg::fetch_res_t  fetch_res_o
);

  align_buffer_pkg::word_sel_t even_word;
  align_buffer_pkg::parcel_t   even_parcel;
  align_buffer_pkg::parcel_t   odd_parcel;
  align_buffer_pkg::parcel_t   live_even;
  align_buffer_pkg::parcel_t   live_odd;

  // Halfword offset moves the even parcel to the following word
  assign even_word = lookup_i.word_sel + align_buffer_pkg::word_sel_t'(lookup_i.half_sel);

  // ====================================================================
  // Parcel select
  // ====================================================================
  always_comb begin
    // Stored parcels, next line starts at its first parcel
    even_parcel = lookup_i.unalign ? rows_i.even_row[0] : rows_i.even_row[even_word];
    odd_parcel  = rows_i.odd_row[lookup_i.word_sel];

    // Same picks from the live line
    live_even = lookup_i.unalign ? line_i[`AB_PARCEL_BITS-1:0] :
                line_i[even_word*2*`AB_PARCEL_BITS +: `AB_PARCEL_BITS];
    live_odd  = line_i[(lookup_i.word_sel*2+1)*`AB_PARCEL_BITS +: `AB_PARCEL_BITS];

    case (src_sel_i)
      align_buffer_pkg::SRC_LINE_WORD: begin
        even_parcel = live_even;
        odd_parcel  = live_odd;
      end
      // Second fetch of a double miss brings only the next line
      align_buffer_pkg::SRC_LINE_EVEN,
      align_buffer_pkg::SRC_SECOND: even_parcel = live_even;
      align_buffer_pkg::SRC_LINE_ODD: odd_parcel = live_odd;
      default: ;
    endcase
  end

  // ====================================================================
  // Output
  // ====================================================================
  always_comb begin
    fetch_res_o.valid = res_valid_i;
    fetch_res_o.miss  = res_miss_i;
    // Odd parcel is the lower half on a halfword offset
    if (lookup_i.half_sel) begin
      fetch_res_o.inst = {even_parcel, odd_parcel};
    end else begin
      fetch_res_o.inst = {odd_parcel, even_parcel};
    end
  end

endmodule

/* rtl/parcel_banks.sv */
// ======================================================================
// Even and odd parcel banks, one row per set
// Even bank keeps the lower halfword of each word, odd bank the upper
// Reads are asynchronous and a write shows one cycle later
// ======================================================================
`timescale 1ns/1ns
`include "align_buffer_config.svh"

module parcel_banks (
  input  logic                          clk_i,
  input  align_buffer_pkg::lookup_t     lookup_i,
  input  align_buffer_pkg::fill_t       fill_i,
  input  align_buffer_pkg::line_t       line_i,
  output align_buffer_pkg::bank_rows_t  rows_o
);

  align_buffer_pkg::bank_row_t even_ram [`AB_NUM_SETS];
  align_buffer_pkg::bank_row_t odd_ram  [`AB_NUM_SETS];

  align_buffer_pkg::bank_row_t even_wr;
  align_buffer_pkg::bank_row_t odd_wr;
  align_buffer_pkg::set_idx_t  wr_idx;

  // Split the incoming line into halfword columns
  always_comb begin
    for (int i = 0; i < `AB_WORDS_PER_LINE; i++) begin
      even_wr[i] = line_i[i*2*`AB_PARCEL_BITS +: `AB_PARCEL_BITS];
      odd_wr[i]  = line_i[(i*2+1)*`AB_PARCEL_BITS +: `AB_PARCEL_BITS];
    end
  end

  // Same set as the tag being written
  assign wr_idx = fill_i.odd_fill ? lookup_i.odd_idx : lookup_i.even_idx;

  always_ff @(posedge clk_i) begin
    if (fill_i.data_we) begin
      even_ram[wr_idx] <= even_wr;
      odd_ram[wr_idx]  <= odd_wr;
    end
  end

  // Even row may come from the next line
  assign rows_o.even_row = even_ram[lookup_i.even_idx];
  assign rows_o.odd_row  = odd_ram[lookup_i.odd_idx];

endmodule

/* rtl/miss_sequencer.sv */
// ======================================================================
// Miss sequencer for the align buffer
// Line requests are held levels, responses are one-cycle pulses
// A double miss runs two line fetches with one idle cycle between
// The fetch request must stay stable until the response is valid
// ======================================================================
`timescale 1ns/1ns
`include "align_buffer_config.svh"

module miss_sequencer (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,
  input  align_buffer_pkg::fetch_req_t  fetch_req_i,
  input  align_buffer_pkg::lookup_t     lookup_i,
  input  logic                          line_res_valid_i,
  output align_buffer_pkg::line_req_t   line_req_o,
  output align_buffer_pkg::fill_t       fill_o,
  output logic                          res_valid_o,
  output logic                          res_miss_o,
  output align_buffer_pkg::src_sel_t    src_sel_o
);

  align_buffer_pkg::seq_state_t state_q;
  align_buffer_pkg::seq_state_t state_d;

  logic                    resp;
  logic                    any_miss;
  logic                    dual_hit;
  logic                    double_miss;
  align_buffer_pkg::addr_t base_addr;

  // Response pulse is ignored in the skip cycle
  assign resp        = line_res_valid_i && (state_q != align_buffer_pkg::SEQ_SKIP);
  assign any_miss    = lookup_i.odd_miss || lookup_i.even_miss;
  assign dual_hit    = fetch_req_i.valid && !any_miss;
  assign double_miss = lookup_i.unalign && lookup_i.odd_miss && lookup_i.even_miss;

  // ====================================================================
  // State machine
  // ====================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      align_buffer_pkg::SEQ_IDLE:
        if (resp && double_miss) state_d = align_buffer_pkg::SEQ_SKIP;
      align_buffer_pkg::SEQ_SKIP:
        state_d = align_buffer_pkg::SEQ_SECOND;
      align_buffer_pkg::SEQ_SECOND:
        if (resp) state_d = align_buffer_pkg::SEQ_IDLE;
      default:
        state_d = align_buffer_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      state_q <= align_buffer_pkg::SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ====================================================================
  // Line request and fill
  // ====================================================================
  assign base_addr = {fetch_req_i.addr[`AB_XLEN-1:`AB_OFFSET_BITS], {`AB_OFFSET_BITS{1'b0}}};

  // Dropped in the response cycle, held low while skipping or in reset
  assign line_req_o.valid = rst_n_i && any_miss && !line_res_valid_i &&
                            (state_q != align_buffer_pkg::SEQ_SKIP);
  // Current line first, next line once the current one hits
  assign line_req_o.addr  = lookup_i.odd_miss ? base_addr :
                            base_addr + align_buffer_pkg::addr_t'(`AB_LINE_BYTES);

  assign fill_o.tag_we   = resp && any_miss;
  assign fill_o.data_we  = resp && any_miss;
  assign fill_o.odd_fill = lookup_i.odd_miss;

  // ====================================================================
  // Response valid and parcel source
  // ====================================================================
  // Nothing is reported while in reset
  assign res_valid_o = rst_n_i &&
                       (dual_hit ||
                        (resp && any_miss && !double_miss &&
                         (state_q == align_buffer_pkg::SEQ_IDLE)) ||
                        (resp && (state_q == align_buffer_pkg::SEQ_SECOND)));
  assign res_miss_o  = any_miss;

  always_comb begin
    if (state_q == align_buffer_pkg::SEQ_SECOND) begin
      src_sel_o = align_buffer_pkg::SRC_SECOND;
    end else if (!any_miss) begin
      src_sel_o = align_buffer_pkg::SRC_CACHE;
    end else if (!lookup_i.unalign) begin
      // Both parcels in one missing line
      src_sel_o = align_buffer_pkg::SRC_LINE_WORD;
    end else if (lookup_i.odd_miss) begin
      src_sel_o = align_buffer_pkg::SRC_LINE_ODD;
    end else begin
      src_sel_o = align_buffer_pkg::SRC_LINE_EVEN;
    end
  end

endmodule

/* rtl/line_tag_store.sv */
// ======================================================================
// Direct-mapped tag store covering the current and the next line
// Tag lookup is combinational, so a hit is seen in the request cycle
// Flush and reset clear every tag in one cycle
// ======================================================================
`timescale 1ns/1ns
`include "align_buffer_config.svh"

module line_tag_store (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  align_buffer_pkg::fetch_req_t fetch_req_i,
  input  align_buffer_pkg::fill_t    fill_i,
  output align_buffer_pkg::lookup_t  lookup_o
);

  // One tag per set, valid bit on top
  align_buffer_pkg::line_tag_t tag_ram [`AB_NUM_SETS];

  logic                                  overflow;
  logic [`AB_TAG_BITS-1:0]               tag_plus1;
  align_buffer_pkg::set_idx_t            wr_idx;
  align_buffer_pkg::line_tag_t           wr_tag;

  // ====================================================================
  // Address split and lookup
  // ====================================================================
  always_comb begin
    lookup_o.half_sel = fetch_req_i.addr[1];
    lookup_o.word_sel = fetch_req_i.addr[`AB_OFFSET_BITS-1:2];
    // Offset 14 means the upper parcel lives in the next line
    lookup_o.unalign  = &{lookup_o.word_sel, lookup_o.half_sel};

    // Current line sits at the address index
    lookup_o.odd_idx  = fetch_req_i.addr[`AB_IDX_BITS+`AB_OFFSET_BITS-1:`AB_OFFSET_BITS];
    {overflow, lookup_o.even_idx} = {1'b0, lookup_o.odd_idx} + lookup_o.unalign;

    // Compare tags carry the valid bit set, so one compare covers both
    lookup_o.odd_tag  = {1'b1, fetch_req_i.addr[`AB_XLEN-1:`AB_IDX_BITS+`AB_OFFSET_BITS]};
    tag_plus1 = fetch_req_i.addr[`AB_XLEN-1:`AB_IDX_BITS+`AB_OFFSET_BITS] + 1'b1;
    // Index wrap moves the next line into the following tag region
    lookup_o.even_tag = overflow ? {1'b1, tag_plus1} : lookup_o.odd_tag;

    // Misses only count with a live request
    lookup_o.odd_miss  = fetch_req_i.valid && (tag_ram[lookup_o.odd_idx] != lookup_o.odd_tag);
    lookup_o.even_miss = fetch_req_i.valid && (tag_ram[lookup_o.even_idx] != lookup_o.even_tag);
  end

  // Fill target picked by the sequencer
  assign wr_idx = fill_i.odd_fill ? lookup_o.odd_idx : lookup_o.even_idx;
  assign wr_tag = fill_i.odd_fill ? lookup_o.odd_tag : lookup_o.even_tag;

  // ====================================================================
  // Tag RAM
  // ====================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      tag_ram <= '{default: '0};
    end else if (fill_i.tag_we) begin
      tag_ram[wr_idx] <= wr_tag;
    end
  end

endmodule

/* rtl/align_buffer_pkg.sv */
// ======================================================================
// Shared types for the align buffer
// Widths come from the config header, so edit sizes there only
// ======================================================================

package align_buffer_pkg;

`include "align_buffer_config.svh"

  typedef logic [`AB_XLEN-1:0]                      addr_t;
  typedef logic [31:0]                              inst_t;
  typedef logic [`AB_PARCEL_BITS-1:0]               parcel_t;
  typedef logic [`AB_LINE_BITS-1:0]                 line_t;
  typedef logic [`AB_IDX_BITS-1:0]                  set_idx_t;
  typedef logic [$clog2(`AB_WORDS_PER_LINE)-1:0]    word_sel_t;
  // Valid bit sits on top of the tag
  typedef logic [`AB_TAG_BITS:0]                    line_tag_t;
  // One parcel per word of a line
  typedef parcel_t [`AB_WORDS_PER_LINE-1:0]         bank_row_t;

  typedef struct packed {logic valid; addr_t addr;} fetch_req_t;
  typedef struct packed {logic valid; logic miss; inst_t inst;} fetch_res_t;
  typedef struct packed {logic valid; addr_t addr;} line_req_t;
  typedef struct packed {logic valid; line_t line;} line_res_t;

  typedef struct packed {
    logic      half_sel;
    word_sel_t word_sel;
    logic      unalign;
    set_idx_t  odd_idx;
    set_idx_t  even_idx;
    line_tag_t odd_tag;
    line_tag_t even_tag;
    logic      odd_miss;
    logic      even_miss;
  } lookup_t;

  typedef struct packed {logic tag_we; logic data_we; logic odd_fill;} fill_t;
  typedef struct packed {bank_row_t even_row; bank_row_t odd_row;} bank_rows_t;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_SKIP, SEQ_SECOND} seq_state_t;
  typedef enum logic [2:0] {
    SRC_CACHE, SRC_LINE_WORD, SRC_LINE_EVEN, SRC_LINE_ODD, SRC_SECOND
  } src_sel_t;

endpackage

/* rtl/align_buffer_config.svh */
// ======================================================================
// Size constants for the instruction align buffer
// Sizes must be powers of two and the line must hold whole 32-bit words
// Only 16-bit parcels are supported by the bank split
// ======================================================================

`ifndef ALIGN_BUFFER_CONFIG_SVH
`define ALIGN_BUFFER_CONFIG_SVH

// Base sizes in bits
`define AB_XLEN         32
`define AB_CACHE_BITS   512
`define AB_LINE_BITS    128
`define AB_PARCEL_BITS  16

// Derived geometry
`define AB_NUM_SETS        (`AB_CACHE_BITS / `AB_LINE_BITS)
`define AB_IDX_BITS        $clog2(`AB_NUM_SETS)
`define AB_OFFSET_BITS     $clog2(`AB_LINE_BITS / 8)
`define AB_TAG_BITS        (`AB_XLEN - `AB_IDX_BITS - `AB_OFFSET_BITS)
`define AB_WORDS_PER_LINE  (`AB_LINE_BITS / 32)
`define AB_LINE_BYTES      (`AB_LINE_BITS / 8)

`endif
